//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_system = 7'b1110011
  } rv_opcode_e;

  // alt funct7 selects sub and sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } rv_alu_op_e;

  // encoded as the branch funct3
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } rv_branch_e;

  // encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } rv_mem_size_e;

  typedef struct packed {
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    rv_alu_op_e            alu_op;
    rv_branch_e            branch_cond;
    rv_mem_size_e          mem_size;
    logic                  load_unsigned;
    // one-hot instruction class
    logic                  is_reg_imm;
    logic                  is_reg_reg;
    logic                  is_lui;
    logic                  is_auipc;
    logic                  is_branch;
    logic                  is_load;
    logic                  is_store;
    logic                  is_ecall;
    logic                  is_illegal;
  } rv_decoded_t;

endpackage

`default_nettype wire

//--- design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  import rv_isa_pkg::*;

  // shared memory port with a word aligned addr
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;
    logic            rstrb;
  } rv_mem_req_t;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_load_wb,
    st_halted
  } rv_state_e;

  localparam logic [xlen-1:0] reset_pc = '0;
  localparam rv_state_e reset_state = st_fetch;

endpackage

`default_nettype wire

//--- design/rv_decode.sv
`default_nettype none

module rv_decode
  import rv_isa_pkg::*;
(
  input  wire [xlen-1:0] insn,
  output rv_decoded_t    dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  rv_alu_op_e      alu_sel;
  logic            bad;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // sub only exists in the reg-reg form and addi ignores bit 30
  always_comb begin
    unique case (funct3)
      3'b000:  alu_sel = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = funct7[5] ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  end

  always_comb begin
    dec = '0;
    bad = 1'b0;
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.rd = insn[11:7];
    unique case (opcode)
      op_lui: begin
        dec.is_lui = 1'b1;
        dec.imm = imm_u;
      end
      op_auipc: begin
        dec.is_auipc = 1'b1;
        dec.imm = imm_u;
      end
      op_imm: begin
        dec.is_reg_imm = 1'b1;
        dec.imm = imm_i;
        dec.alu_op = alu_sel;
        // shift immediates carry a funct7 in the upper bits
        if (funct3 == 3'b001 && funct7 != funct7_base) begin
          bad = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != funct7_base && funct7 != funct7_alt) begin
          bad = 1'b1;
        end
      end
      op_reg: begin
        dec.is_reg_reg = 1'b1;
        dec.alu_op = alu_sel;
        if (funct7 == funct7_alt) begin
          bad = !(funct3 == 3'b000 || funct3 == 3'b101);
        end else begin
          bad = funct7 != funct7_base;
        end
      end
      op_branch: begin
        dec.is_branch = 1'b1;
        dec.imm = imm_b;
        dec.branch_cond = rv_branch_e'(funct3);
        bad = funct3[2:1] == 2'b01;
      end
      op_load: begin
        dec.is_load = 1'b1;
        dec.imm = imm_i;
        dec.mem_size = rv_mem_size_e'(funct3[1:0]);
        dec.load_unsigned = funct3[2];
        bad = funct3[1:0] == 2'b11 || funct3 == 3'b110;
      end
      op_store: begin
        dec.is_store = 1'b1;
        dec.imm = imm_s;
        dec.mem_size = rv_mem_size_e'(funct3[1:0]);
        bad = funct3[2] || funct3[1:0] == 2'b11;
      end
      op_system: begin
        // only ecall with every other field zero
        dec.is_ecall = 1'b1;
        bad = insn[31:7] != '0;
      end
      default: begin
        bad = 1'b1;
      end
    endcase
    if (bad) begin
      {dec.is_reg_imm, dec.is_reg_reg, dec.is_lui, dec.is_auipc, dec.is_branch,
       dec.is_load, dec.is_store, dec.is_ecall} = '0;
      dec.is_illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`default_nettype none

module rv_regfile
  import rv_isa_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire [reg_addr_w-1:0] rs1,
  input  wire [reg_addr_w-1:0] rs2,
  input  wire [reg_addr_w-1:0] waddr,
  input  wire                  we,
  input  wire [xlen-1:0]       wdata,
  output logic [xlen-1:0]      rs1_data,
  output logic [xlen-1:0]      rs2_data
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  a_wdata_known: assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wdata))
    else $error("regfile: unknown write data to x%0d", waddr);

endmodule

`default_nettype wire

//--- design/rv_alu.sv
`default_nettype none

module rv_alu
  import rv_isa_pkg::*;
(
  input  wire rv_decoded_t dec,
  input  wire [xlen-1:0]   pc,
  input  wire [xlen-1:0]   rs1_data,
  input  wire [xlen-1:0]   rs2_data,
  output logic [xlen-1:0]  result,
  output logic             branch_taken
);

  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            cond_true;

  assign op_b = dec.is_reg_reg ? rs2_data : dec.imm;
  assign shamt = op_b[4:0];

  always_comb begin
    if (dec.is_lui) begin
      result = dec.imm;
    end else if (dec.is_auipc) begin
      result = pc + dec.imm;
    end else begin
      unique case (dec.alu_op)
        alu_add:  result = rs1_data + op_b;
        alu_sub:  result = rs1_data - op_b;
        alu_sll:  result = rs1_data << shamt;
        alu_slt:  result = {31'b0, $signed(rs1_data) < $signed(op_b)};
        alu_sltu: result = {31'b0, rs1_data < op_b};
        alu_xor:  result = rs1_data ^ op_b;
        alu_srl:  result = rs1_data >> shamt;
        alu_sra:  result = $signed(rs1_data) >>> shamt;
        alu_or:   result = rs1_data | op_b;
        default:  result = rs1_data & op_b;
      endcase
    end
  end

  always_comb begin
    unique case (dec.branch_cond)
      br_beq:  cond_true = rs1_data == rs2_data;
      br_bne:  cond_true = rs1_data != rs2_data;
      br_blt:  cond_true = $signed(rs1_data) < $signed(rs2_data);
      br_bge:  cond_true = $signed(rs1_data) >= $signed(rs2_data);
      br_bltu: cond_true = rs1_data < rs2_data;
      default: cond_true = rs1_data >= rs2_data;
    endcase
  end

  assign branch_taken = dec.is_branch && cond_true;

endmodule

`default_nettype wire

//--- design/rv_lsu.sv
`default_nettype none

module rv_lsu
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  wire rv_decoded_t dec,
  input  wire [xlen-1:0]   rs1_data,
  input  wire [xlen-1:0]   rs2_data,
  input  wire [xlen-1:0]   mem_rdata,
  input  wire [1:0]        load_addr_lo,
  output rv_mem_req_t      data_req,
  output logic [1:0]       addr_lo,
  output logic [xlen-1:0]  load_result
);

  logic [xlen-1:0] addr;
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;
  logic            half_misaligned;

  // decode already chose the I or S immediate
  assign addr = rs1_data + dec.imm;
  assign addr_lo = addr[1:0];

  always_comb begin
    data_req = '0;
    data_req.addr = {addr[xlen-1:2], 2'b00};
    data_req.rstrb = dec.is_load;
    unique case (dec.mem_size)
      size_byte: begin
        data_req.wdata = {4{rs2_data[7:0]}};
        data_req.wstrb = 4'b0001 << addr[1:0];
      end
      size_half: begin
        data_req.wdata = {2{rs2_data[15:0]}};
        data_req.wstrb = 4'b0011 << addr[1:0];
      end
      default: begin
        data_req.wdata = rs2_data;
        data_req.wstrb = 4'b1111;
      end
    endcase
    if (!dec.is_store) begin
      data_req.wstrb = '0;
    end
  end

  // load lane comes from the captured address bits
  assign ld_byte = mem_rdata[{load_addr_lo, 3'b000} +: 8];
  assign ld_half = mem_rdata[{load_addr_lo[1], 4'b0000} +: 16];

  always_comb begin
    unique case (dec.mem_size)
      size_byte: load_result = {{24{ld_byte[7] && !dec.load_unsigned}}, ld_byte};
      size_half: load_result = {{16{ld_half[15] && !dec.load_unsigned}}, ld_half};
      default:   load_result = mem_rdata;
    endcase
  end

  // loads need both the live and the captured address odd, so a load whose rd
  // overwrites its own rs1 cannot trip the check after write-back
  assign half_misaligned = dec.mem_size == size_half && addr[0] &&
                           (dec.is_store || dec.is_load && load_addr_lo[0]);

  always_comb begin
    a_half_aligned: assert final (half_misaligned !== 1'b1)
      else $error("lsu: half access at odd address %h", addr);
  end

endmodule

`default_nettype wire

//--- design/rv_control.sv
`default_nettype none

module rv_control
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire rv_decoded_t      dec,
  input  wire [xlen-1:0]        alu_result,
  input  wire [xlen-1:0]        load_result,
  input  wire                   branch_taken,
  input  wire rv_mem_req_t      data_req,
  input  wire [1:0]             addr_lo,
  input  wire [xlen-1:0]        mem_rdata,
  output rv_mem_req_t           mem_req,
  output logic [xlen-1:0]       insn,
  output logic [xlen-1:0]       pc,
  output logic [1:0]            load_addr_lo,
  output logic                  rf_we,
  output logic [reg_addr_w-1:0] rf_waddr,
  output logic [xlen-1:0]       rf_wdata,
  output logic                  halt,
  output logic                  illegal
);

  rv_state_e             state;
  logic [xlen-1:0]       insn_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= reset_state;
      pc <= reset_pc;
      illegal <= 1'b0;
    end else begin
      unique case (state)
        st_fetch: begin
          state <= st_exec;
        end
        st_exec: begin
          if (dec.is_ecall || dec.is_illegal) begin
            state <= st_halted;
            illegal <= dec.is_illegal;
          end else begin
            pc <= branch_taken ? pc + dec.imm : pc + 32'd4;
            state <= dec.is_load ? st_load_wb : st_fetch;
          end
        end
        st_load_wb: begin
          state <= st_fetch;
        end
        default: begin
          state <= st_halted;
        end
      endcase
    end
  end

  // the fetched word arrives in exec and is kept for load write-back
  always_ff @(posedge clk) begin
    if (state == st_exec) begin
      insn_q <= mem_rdata;
      load_addr_lo <= addr_lo;
    end
  end

  assign insn = (state == st_exec) ? mem_rdata : insn_q;
  assign halt = state == st_halted;

  always_comb begin
    mem_req = '0;
    if (state == st_fetch) begin
      mem_req.addr = pc;
      mem_req.rstrb = 1'b1;
    end else if (state == st_exec && (dec.is_load || dec.is_store)) begin
      mem_req = data_req;
    end
  end

  always_comb begin
    rf_we = 1'b0;
    rf_waddr = dec.rd;
    rf_wdata = alu_result;
    if (state == st_exec) begin
      rf_we = dec.is_reg_imm || dec.is_reg_reg || dec.is_lui || dec.is_auipc;
    end else if (state == st_load_wb) begin
      rf_we = 1'b1;
      rf_wdata = load_result;
    end
  end

  a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    state == st_fetch |-> pc[1:0] == 2'b00)
    else $error("control: fetch from unaligned pc %h", pc);

  // once halted the port and the register file stay quiet
  a_halt_idle: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && !mem_req.rstrb && mem_req.wstrb == '0 && !rf_we)
    else $error("control: activity after halt");

endmodule

`default_nettype wire

//--- design/rv_core.sv
`default_nettype none

module rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  output rv_mem_req_t     mem_req,
  input  wire [xlen-1:0]  mem_rdata,
  output logic            halt,
  output logic            illegal
);

  rv_decoded_t           dec;
  rv_mem_req_t           data_req;
  logic [xlen-1:0]       insn;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       load_result;
  logic                  branch_taken;
  logic [1:0]            addr_lo;
  logic [1:0]            load_addr_lo;
  logic                  rf_we;
  logic [reg_addr_w-1:0] rf_waddr;
  logic [xlen-1:0]       rf_wdata;

  rv_control i_control (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec),
    .alu_result   (alu_result),
    .load_result  (load_result),
    .branch_taken (branch_taken),
    .data_req     (data_req),
    .addr_lo      (addr_lo),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .insn         (insn),
    .pc           (pc),
    .load_addr_lo (load_addr_lo),
    .rf_we        (rf_we),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .halt         (halt),
    .illegal      (illegal)
  );

  rv_decode i_decode (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .waddr    (rf_waddr),
    .we       (rf_we),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_alu (
    .dec          (dec),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu i_lsu (
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .mem_rdata    (mem_rdata),
    .load_addr_lo (load_addr_lo),
    .data_req     (data_req),
    .addr_lo      (addr_lo),
    .load_result  (load_result)
  );

endmodule

`default_nettype wire

//--- include/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// expected effect of one instruction
typedef struct packed {
  logic [31:0] next_pc;
  logic        store_en;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  logic [3:0]  store_strb;
  logic        halt;
  logic        illegal;
} rv_ref_result_t;

function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] funct3,
                                      input logic [4:0] rd);
  return {funct7, rs2, rs1, funct3, rd, op_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] funct3, input logic [4:0] rd,
                                      input rv_opcode_e opcode);
  return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] funct3);
  return {imm[11:5], rs2, rs1, funct3, imm[4:0], op_store};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] funct3);
  return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], op_branch};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input rv_opcode_e opcode);
  return {imm, rd, opcode};
endfunction

// executes insn at pc on the model registers and only reads mem
function automatic rv_ref_result_t rv_ref_step(input logic [31:0] insn,
                                               input logic [31:0] pc,
                                               inout logic [31:0] regs [32],
                                               input logic [31:0] mem []);
  rv_ref_result_t res;
  logic [2:0]     f3;
  logic [31:0]    a;
  logic [31:0]    b;
  logic [31:0]    addr;
  logic [31:0]    word;
  logic [31:0]    val;
  logic           wr;
  logic           taken;
  res = '0;
  f3 = insn[14:12];
  a = regs[insn[19:15]];
  b = regs[insn[24:20]];
  val = '0;
  wr = 1'b0;
  taken = 1'b0;
  res.next_pc = pc + 32'd4;
  case (insn[6:0])
    op_lui, op_auipc: begin
      wr = 1'b1;
      val = {insn[31:12], 12'b0};
      if (insn[6:0] == op_auipc) begin
        val = val + pc;
      end
    end
    op_imm, op_reg: begin
      wr = 1'b1;
      if (insn[6:0] == op_imm) begin
        b = {{20{insn[31]}}, insn[31:20]};
      end
      case (f3)
        3'b000: val = (insn[6:0] == op_reg && insn[30]) ? a - b : a + b;
        3'b001: val = a << b[4:0];
        3'b010: val = {31'b0, $signed(a) < $signed(b)};
        3'b011: val = {31'b0, a < b};
        3'b100: val = a ^ b;
        3'b101: begin
          if (insn[30]) begin
            val = $signed(a) >>> b[4:0];
          end else begin
            val = a >> b[4:0];
          end
        end
        3'b110: val = a | b;
        default: val = a & b;
      endcase
    end
    op_branch: begin
      case (f3)
        3'b000: taken = a == b;
        3'b001: taken = a != b;
        3'b100: taken = $signed(a) < $signed(b);
        3'b101: taken = $signed(a) >= $signed(b);
        3'b110: taken = a < b;
        default: taken = a >= b;
      endcase
      if (taken) begin
        res.next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end
    end
    op_load: begin
      wr = 1'b1;
      addr = a + {{20{insn[31]}}, insn[31:20]};
      word = mem[addr >> 2];
      case (f3[1:0])
        2'b00: begin
          val = word[{addr[1:0], 3'b000} +: 8];
          val = {{24{val[7] && !f3[2]}}, val[7:0]};
        end
        2'b01: begin
          val = word[{addr[1], 4'b0000} +: 16];
          val = {{16{val[15] && !f3[2]}}, val[15:0]};
        end
        default: val = word;
      endcase
    end
    op_store: begin
      addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
      res.store_en = 1'b1;
      res.store_addr = {addr[31:2], 2'b00};
      case (f3[1:0])
        2'b00: begin
          res.store_data = {4{b[7:0]}};
          res.store_strb = 4'b0001 << addr[1:0];
        end
        2'b01: begin
          res.store_data = {2{b[15:0]}};
          res.store_strb = 4'b0011 << addr[1:0];
        end
        default: begin
          res.store_data = b;
          res.store_strb = 4'b1111;
        end
      endcase
    end
    default: begin
      // ecall or anything unknown stops the model
      res.halt = 1'b1;
      res.illegal = insn[6:0] != op_system || insn[31:7] != '0;
      res.next_pc = pc;
    end
  endcase
  if (wr && insn[11:7] != 5'd0) begin
    regs[insn[11:7]] = val;
  end
  return res;
endfunction

`endif

//--- test/rv_core_tb.sv
`default_nettype none

module rv_core_tb
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
;

  localparam int mem_words = 1024;
  localparam int num_programs = 7;
  localparam int fetch_timeout = 200;
  localparam int max_steps = 2000;
  localparam logic [31:0] data_base = 32'h0000_0800;
  localparam logic [31:0] ecall_insn = 32'h0000_0073;
  localparam logic [31:0] unknown_insn = 32'h0000_007f;

  logic        clk;
  logic        rst;
  rv_mem_req_t mem_req;
  logic [31:0] mem_rdata;
  logic        halt;
  logic        illegal;

  logic [31:0] mem [mem_words];
  logic [31:0] model_mem [];
  logic [31:0] model_regs [32];
  logic [31:0] prog [$];
  integer      seed;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          progs_started = 0;
  int          progs_checked = 0;
  bit          timed_out = 1'b0;

  `include "rv_ref_model.svh"

  rv_core i_rv_core (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .halt      (halt),
    .illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // read-first synchronous memory with byte strobes
  always @(posedge clk) begin
    if (mem_req.rstrb === 1'b1) begin
      mem_rdata <= mem[mem_req.addr[11:2]];
    end
    for (int i = 0; i < 4; i++) begin
      if (mem_req.wstrb[i] === 1'b1) begin
        mem[mem_req.addr[11:2]][8*i +: 8] <= mem_req.wdata[8*i +: 8];
      end
    end
  end

  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = idx;
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic void emit(input logic [31:0] w);
    prog.push_back(w);
  endfunction

  // lui plus addi with the upper part rounded for the sign of the low twelve bits
  task automatic emit_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = v + 32'h800;
    emit(enc_u(upper[31:12], rd, op_lui));
    emit(enc_i(v[11:0], rd, 3'b000, rd, op_imm));
  endtask

  // results become visible as a sw to data_base + 0x40
  task automatic emit_observe(input logic [4:0] rs);
    emit(enc_s(12'h040, rs, 5'd10, 3'b010));
  endtask

  task automatic start_program();
    prog.delete();
    emit_const(5'd10, data_base);
  endtask

  task automatic build_alu_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    int          round;
    int          f3;
    int          k;
    start_program();
    for (round = 0; round < 2; round++) begin
      for (f3 = 0; f3 < 8; f3++) begin
        for (k = 0; k < ((f3 == 5) ? 2 : 1); k++) begin
          a = $random(seed);
          imm = $random(seed);
          if (f3 == 1 || f3 == 5) begin
            imm = {(k == 1) ? funct7_alt : funct7_base, imm[4:0]};
          end
          emit_const(5'd1, a);
          emit(enc_i(imm, 5'd1, 3'(f3), 5'd3, op_imm));
          emit_observe(5'd3);
        end
      end
      for (f3 = 0; f3 < 8; f3++) begin
        for (k = 0; k < ((f3 == 0 || f3 == 5) ? 2 : 1); k++) begin
          a = $random(seed);
          b = $random(seed);
          emit_const(5'd1, a);
          emit_const(5'd2, b);
          emit(enc_r((k == 1) ? funct7_alt : funct7_base, 5'd2, 5'd1, 3'(f3), 5'd3));
          emit_observe(5'd3);
        end
      end
    end
    emit(ecall_insn);
  endtask

  // a taken branch skips the addi behind it
  task automatic build_branch_program();
    logic [31:0] a;
    logic [31:0] b;
    int          f3;
    int          pair;
    start_program();
    for (f3 = 0; f3 < 8; f3++) begin
      if (f3 == 2 || f3 == 3) begin
        continue;
      end
      for (pair = 0; pair < 3; pair++) begin
        a = $random(seed);
        b = $random(seed);
        if (pair == 1) begin
          b = a;
        end else if (pair == 2) begin
          b = a ^ 32'h8000_0000;
        end
        emit_const(5'd1, a);
        emit_const(5'd2, b);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'(f3)));
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, op_imm));
      end
    end
    emit(ecall_insn);
  endtask

  task automatic emit_load(input logic [11:0] offset, input logic [2:0] f3);
    emit(enc_i(offset, 5'd10, f3, 5'd3, op_load));
    emit_observe(5'd3);
  endtask

  task automatic build_mem_program();
    logic [11:0] base;
    int          off;
    int          k;
    start_program();
    emit_const(5'd1, $random(seed));
    emit_const(5'd2, 32'h807f_7f80);
    for (off = 0; off < 4; off++) begin
      emit(enc_s(12'h080 + 12'(off), 5'd1, 5'd10, 3'b000));
    end
    emit(enc_s(12'h090, 5'd1, 5'd10, 3'b001));
    emit(enc_s(12'h092, 5'd1, 5'd10, 3'b001));
    emit(enc_s(12'h0a0, 5'd1, 5'd10, 3'b010));
    emit(enc_s(12'h0b0, 5'd2, 5'd10, 3'b010));
    // byte, half and word written words, a fixed mixed-sign word and fill data
    for (k = 0; k < 5; k++) begin
      base = (k == 4) ? 12'h100 : 12'h080 + 12'(k * 16);
      for (off = 0; off < 4; off++) begin
        emit_load(base + 12'(off), 3'b000);
        emit_load(base + 12'(off), 3'b100);
      end
      for (off = 0; off < 4; off += 2) begin
        emit_load(base + 12'(off), 3'b001);
        emit_load(base + 12'(off), 3'b101);
      end
      emit_load(base, 3'b010);
    end
    emit(ecall_insn);
  endtask

  task automatic build_upper_program();
    logic [31:0] imm;
    int          k;
    start_program();
    for (k = 0; k < 4; k++) begin
      imm = $random(seed);
      emit(enc_u(imm[19:0], 5'd3, op_lui));
      emit_observe(5'd3);
      emit(enc_u(imm[31:12], 5'd3, op_auipc));
      emit_observe(5'd3);
    end
    emit(ecall_insn);
  endtask

  task automatic build_halt_program(input bit with_unknown);
    start_program();
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd3, op_imm));
    emit_observe(5'd3);
    emit(with_unknown ? unknown_insn : ecall_insn);
    // never fetched once the core stops
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, op_imm));
    emit_observe(5'd3);
    emit(ecall_insn);
  endtask

  task automatic load_image();
    int i;
    model_mem = new[mem_words];
    for (i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    for (i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
      model_mem[i] = prog[i];
    end
  endtask

  task automatic run_program();
    int cycles;
    @(posedge clk);
    rst <= 1'b1;
    load_image();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    progs_started++;
    cycles = 0;
    while (progs_checked != progs_started && cycles < 20000) begin
      @(posedge clk);
      cycles++;
    end
    if (progs_checked != progs_started) begin
      $display("timeout: program %0d was still running after 20000 cycles", progs_started);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    end
  endtask

  // follows one program from the first fetch after reset until halt
  task automatic check_program();
    logic [31:0]    exp_pc;
    rv_ref_result_t res;
    int             steps;
    int             cycles;
    int             i;
    bit             running;
    for (i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    exp_pc = reset_pc;
    steps = 0;
    running = 1'b1;
    check_value("halt after reset", {31'b0, halt}, 32'd0);
    check_value("illegal after reset", {31'b0, illegal}, 32'd0);
    while (running) begin
      check_value($sformatf("read strobe of fetch %0d", steps), {31'b0, mem_req.rstrb}, 32'd1);
      check_value($sformatf("address of fetch %0d", steps), mem_req.addr, exp_pc);
      check_value("write strobe during fetch", {28'b0, mem_req.wstrb}, 32'd0);
      if (mem_req.addr !== exp_pc) begin
        $display("fetch address diverged from the model, rest of program skipped");
        running = 1'b0;
      end else begin
        res = rv_ref_step(model_mem[exp_pc[11:2]], exp_pc, model_regs, model_mem);
        @(negedge clk);
        if (res.store_en) begin
          check_value("store address", mem_req.addr, res.store_addr);
          check_value("store strobe", {28'b0, mem_req.wstrb}, {28'b0, res.store_strb});
          check_value("store data", mem_req.wdata, res.store_data);
          for (i = 0; i < 4; i++) begin
            if (res.store_strb[i]) begin
              model_mem[res.store_addr[11:2]][8*i +: 8] = res.store_data[8*i +: 8];
            end
          end
        end else begin
          check_value("write strobe outside a store", {28'b0, mem_req.wstrb}, 32'd0);
        end
        cycles = 0;
        do begin
          @(negedge clk);
          cycles++;
        end while (mem_req.rstrb !== 1'b1 && halt !== 1'b1 && cycles < fetch_timeout);
        if (mem_req.rstrb !== 1'b1 && halt !== 1'b1) begin
          $display("timeout: no fetch and no halt within %0d cycles after pc %h",
                   fetch_timeout, exp_pc);
          timed_out = 1'b1;
          running = 1'b0;
        end else if (res.halt) begin
          check_value("halt after stopping instruction", {31'b0, halt}, 32'd1);
          check_value("cycles from exec to halt", cycles, 32'd1);
          check_value("illegal flag", {31'b0, illegal}, {31'b0, res.illegal});
          repeat (4) begin
            @(negedge clk);
            check_value("read strobe while halted", {31'b0, mem_req.rstrb}, 32'd0);
            check_value("halt stays high", {31'b0, halt}, 32'd1);
          end
          running = 1'b0;
        end else begin
          check_value("halt while running", {31'b0, halt}, 32'd0);
          running = halt !== 1'b1;
          exp_pc = res.next_pc;
          steps++;
          if (steps > max_steps) begin
            $display("program ran past %0d instructions without halting", max_steps);
            errors++;
            running = 1'b0;
          end
        end
      end
    end
  endtask

  // comparison process with one pass per program
  initial begin
    int p;
    int cycles;
    for (p = 0; p < num_programs && !timed_out; p++) begin
      cycles = 0;
      while (progs_started == p && cycles < 400) begin
        @(negedge clk);
        cycles++;
      end
      if (progs_started == p) begin
        $display("timeout: program %0d was never started", p + 1);
        timed_out = 1'b1;
      end else begin
        check_program();
      end
      progs_checked++;
    end
  end

  initial begin
    int errs;
    rst = 1'b1;
    mem_rdata = '0;
    seed = 32'he23f;
    errs = errors;
    start_program();
    emit(ecall_insn);
    run_program();
    report_test(1, "reset state and first fetch", errs);
    if (!timed_out) begin
      errs = errors;
      build_alu_program();
      run_program();
      report_test(2, "reg-imm and reg-reg operations", errs);
    end
    if (!timed_out) begin
      errs = errors;
      build_branch_program();
      run_program();
      report_test(3, "branch conditions", errs);
    end
    if (!timed_out) begin
      errs = errors;
      build_mem_program();
      run_program();
      report_test(4, "byte, half and word loads and stores", errs);
    end
    if (!timed_out) begin
      errs = errors;
      build_upper_program();
      run_program();
      report_test(5, "lui and auipc", errs);
    end
    if (!timed_out) begin
      errs = errors;
      build_halt_program(1'b0);
      run_program();
      if (!timed_out) begin
        build_halt_program(1'b1);
        run_program();
      end
      report_test(6, "ecall and unknown opcode halt", errs);
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+include
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_control.sv
design/rv_core.sv
test/rv_core_tb.sv
